// File: design/rtc_pkg.sv
// shared widths, register map, APB state encoding and reset values for the RTC design
package rtc_pkg;

    // ========================================
    // bus widths
    // ========================================

    // APB data bus
    localparam int DATA_WIDTH = 32;
    // APB address bus, word addresses
    localparam int ADDR_WIDTH = 12;

    // flops in the CLK1HZ synchronizer
    localparam int SYNC_STAGES = 2;

    // ========================================
    // register map
    // ========================================

    // undecoded addresses read zero, writes dropped
    typedef enum logic [ADDR_WIDTH-1:0] {
        // seconds counter, read only
        RA_DR   = 12'h000,
        // match value
        RA_MR   = 12'h004,
        // load value, write loads the counter
        RA_LR   = 12'h008,
        // control, bit 0 counts
        RA_CR   = 12'h00C,
        // interrupt mask
        RA_IMSC = 12'h010,
        // raw status
        RA_RIS  = 12'h014,
        // masked status
        RA_MIS  = 12'h018,
        // interrupt clear, write 1
        RA_ICR  = 12'h01C
    } reg_addr_e;

    // ========================================
    // APB slave FSM
    // ========================================

    typedef enum logic [2:0] {
        ST_IDLE  = 3'b000,
        ST_SETUP = 3'b001,
        ST_WRITE = 3'b010,
        ST_READ  = 3'b011,
        ST_RESP  = 3'b100
    } apb_state_e;

    // ========================================
    // reset values
    // ========================================

    // seconds count after reset
    localparam logic [DATA_WIDTH-1:0] RST_COUNT = '0;
    // match register after reset
    localparam logic [DATA_WIDTH-1:0] RST_MATCH = '0;
    // load readback register after reset
    localparam logic [DATA_WIDTH-1:0] RST_LOAD  = '0;
    // read data bus before the first read
    localparam logic [DATA_WIDTH-1:0] RST_RDATA = '0;

endpackage

// File: design/rtc_tick_sync.sv
// brings the slow CLK1HZ level into PCLK and pulses tick for one cycle per rising edge
`timescale 1ns/1ps

module rtc_tick_sync (
    input  logic PCLK,
    input  logic PRESETn,
    input  logic CLK1HZ,
    output logic tick
);

    // sync chain, bit 0 samples the pin
    logic [rtc_pkg::SYNC_STAGES-1:0] sync_q;
    // last synchronized level for edge detect
    logic                            hist_q;
    logic                            sync_lvl;

    // synchronized level at the end of the chain
    assign sync_lvl = sync_q[rtc_pkg::SYNC_STAGES-1];

    // shift CLK1HZ through the chain
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[rtc_pkg::SYNC_STAGES-2:0], CLK1HZ};
        end
    end

    // rising edge, registered so tick comes out of a flop
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            hist_q <= 1'b0;
            tick   <= 1'b0;
        end else begin
            hist_q <= sync_lvl;
            tick   <= sync_lvl & ~hist_q;
        end
    end

    // one pulse per edge, never a double tick
    a_tick_single: assert property (@(posedge PCLK) disable iff (!PRESETn)
        tick |=> !tick);

endmodule

// File: design/rtc_counter.sv
// seconds counter that counts synchronized ticks and takes loads from the APB side
`timescale 1ns/1ps

module rtc_counter (
    input  logic                           PCLK,
    input  logic                           PRESETn,
    // one-cycle tick from the synchronizer
    input  logic                           tick,
    // counting enable, CR bit 0
    input  logic                           enable,
    // load strobe and value from APB
    input  logic                           load_wr,
    input  logic [rtc_pkg::DATA_WIDTH-1:0] load_data,
    // current time
    output logic [rtc_pkg::DATA_WIDTH-1:0] count,
    // high on the cycle a new count shows
    output logic                           count_upd
);

    // ========================================
    // count register
    // ========================================

    // load beats a tick in the same cycle
    // count wraps from all ones to zero
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            count     <= rtc_pkg::RST_COUNT;
            count_upd <= 1'b0;
        end else if (load_wr) begin
            count     <= load_data;
            count_upd <= 1'b1;
        end else if (tick && enable) begin
            count     <= count + 1'b1;
            count_upd <= 1'b1;
        end else begin
            count_upd <= 1'b0;
        end
    end

    // ========================================
    // checks
    // ========================================

    // any change of count traces back to a tick or a load one cycle before
    a_count_cause: assert property (@(posedge PCLK) disable iff (!PRESETn)
        $changed(count) |-> $past(tick || load_wr));

endmodule

// File: design/rtc_alarm.sv
// match register, interrupt mask and sticky raw status that raise the RTC interrupt
`timescale 1ns/1ps

module rtc_alarm (
    input  logic                           PCLK,
    input  logic                           PRESETn,
    // time from the counter
    input  logic [rtc_pkg::DATA_WIDTH-1:0] count,
    input  logic                           count_upd,
    // match register write
    input  logic                           match_wr,
    input  logic [rtc_pkg::DATA_WIDTH-1:0] match_data,
    // mask register write
    input  logic                           mask_wr,
    input  logic                           mask_data,
    // clear raw status
    input  logic                           clear,
    output logic [rtc_pkg::DATA_WIDTH-1:0] match_value,
    output logic                           mask,
    output logic                           raw_status,
    // registered masked interrupt
    output logic                           intr
);

    logic hit;

    // compare only when the counter just moved
    assign hit = count_upd && (count == match_value);

    // ========================================
    // match and mask registers
    // ========================================

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            match_value <= rtc_pkg::RST_MATCH;
            mask        <= 1'b0;
        end else begin
            if (match_wr) begin
                match_value <= match_data;
            end
            if (mask_wr) begin
                mask <= mask_data;
            end
        end
    end

    // ========================================
    // status and interrupt
    // ========================================

    // sticky status, a new hit wins over a clear
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            raw_status <= 1'b0;
        end else if (hit) begin
            raw_status <= 1'b1;
        end else if (clear) begin
            raw_status <= 1'b0;
        end
    end

    // interrupt pin straight from a flop
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            intr <= 1'b0;
        end else begin
            intr <= raw_status & mask;
        end
    end

    // interrupt only after the mask was open
    a_intr_masked: assert property (@(posedge PCLK) disable iff (!PRESETn)
        intr |-> $past(mask));

endmodule

// File: design/rtc_control.sv
// APB slave FSM with register decode, write strobes, CR and LR, and registered read data
`timescale 1ns/1ps

module rtc_control (
    input  logic                           PCLK,
    input  logic                           PRESETn,
    // APB slave side
    input  logic                           PSEL,
    input  logic                           PENABLE,
    input  logic                           PWRITE,
    input  logic [rtc_pkg::ADDR_WIDTH-1:0] PADDR,
    input  logic [rtc_pkg::DATA_WIDTH-1:0] PWDATA,
    output logic [rtc_pkg::DATA_WIDTH-1:0] PRDATA,
    output logic                           PREADY,
    // read sources
    input  logic [rtc_pkg::DATA_WIDTH-1:0] count,
    input  logic [rtc_pkg::DATA_WIDTH-1:0] match_value,
    input  logic                           mask,
    input  logic                           raw_status,
    // counter side
    output logic                           load_wr,
    output logic [rtc_pkg::DATA_WIDTH-1:0] load_data,
    output logic                           enable,
    // alarm side
    output logic                           match_wr,
    output logic [rtc_pkg::DATA_WIDTH-1:0] match_data,
    output logic                           mask_wr,
    output logic                           mask_data,
    output logic                           clear
);

    rtc_pkg::apb_state_e state_q;
    rtc_pkg::apb_state_e state_d;
    rtc_pkg::reg_addr_e  addr;

    // last value written to LR
    logic [rtc_pkg::DATA_WIDTH-1:0] lr_q;
    logic [rtc_pkg::DATA_WIDTH-1:0] rd_mux;
    logic                           cr_wr;

    // word address seen as a register name
    assign addr = rtc_pkg::reg_addr_e'(PADDR);

    // ========================================
    // APB FSM
    // ========================================

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            state_q <= rtc_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            // setup phase starts a transfer
            rtc_pkg::ST_IDLE: begin
                if (PSEL && !PENABLE) begin
                    state_d = rtc_pkg::ST_SETUP;
                end
            end
            // access phase picks direction
            rtc_pkg::ST_SETUP: begin
                if (PSEL && PENABLE) begin
                    state_d = PWRITE ? rtc_pkg::ST_WRITE : rtc_pkg::ST_READ;
                end
            end
            rtc_pkg::ST_WRITE: state_d = rtc_pkg::ST_RESP;
            rtc_pkg::ST_READ:  state_d = rtc_pkg::ST_RESP;
            rtc_pkg::ST_RESP:  state_d = rtc_pkg::ST_IDLE;
            default:           state_d = rtc_pkg::ST_IDLE;
        endcase
    end

    // one-cycle ready after the write or read state
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            PREADY <= 1'b0;
        end else begin
            PREADY <= (state_q == rtc_pkg::ST_WRITE) || (state_q == rtc_pkg::ST_READ);
        end
    end

    // ========================================
    // write decode
    // ========================================

    // strobes live for the single ST_WRITE cycle
    always_comb begin
        load_wr  = 1'b0;
        match_wr = 1'b0;
        mask_wr  = 1'b0;
        cr_wr    = 1'b0;
        clear    = 1'b0;
        if (state_q == rtc_pkg::ST_WRITE) begin
            case (addr)
                rtc_pkg::RA_MR:   match_wr = 1'b1;
                rtc_pkg::RA_LR:   load_wr  = 1'b1;
                rtc_pkg::RA_CR:   cr_wr    = 1'b1;
                rtc_pkg::RA_IMSC: mask_wr  = 1'b1;
                // ICR only acts on a written 1
                rtc_pkg::RA_ICR:  clear    = PWDATA[0];
                default:          clear    = 1'b0;
            endcase
        end
    end

    // write data fans out unchanged
    assign load_data  = PWDATA;
    assign match_data = PWDATA;
    assign mask_data  = PWDATA[0];

    // CR enable and LR readback
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            enable <= 1'b0;
            lr_q   <= rtc_pkg::RST_LOAD;
        end else begin
            if (cr_wr) begin
                enable <= PWDATA[0];
            end
            if (load_wr) begin
                lr_q <= PWDATA;
            end
        end
    end

    // ========================================
    // read path
    // ========================================

    // single-bit registers sit in bit 0
    always_comb begin
        case (addr)
            rtc_pkg::RA_DR:   rd_mux = count;
            rtc_pkg::RA_MR:   rd_mux = match_value;
            rtc_pkg::RA_LR:   rd_mux = lr_q;
            rtc_pkg::RA_CR:   rd_mux = {{(rtc_pkg::DATA_WIDTH-1){1'b0}}, enable};
            rtc_pkg::RA_IMSC: rd_mux = {{(rtc_pkg::DATA_WIDTH-1){1'b0}}, mask};
            rtc_pkg::RA_RIS:  rd_mux = {{(rtc_pkg::DATA_WIDTH-1){1'b0}}, raw_status};
            rtc_pkg::RA_MIS:  rd_mux = {{(rtc_pkg::DATA_WIDTH-1){1'b0}}, raw_status & mask};
            // ICR and holes read zero
            default:          rd_mux = '0;
        endcase
    end

    // captured for PREADY and held until the next read
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            PRDATA <= rtc_pkg::RST_RDATA;
        end else if (state_q == rtc_pkg::ST_READ) begin
            PRDATA <= rd_mux;
        end
    end

    // ========================================
    // protocol checks
    // ========================================

    a_pready_pulse: assert property (@(posedge PCLK) disable iff (!PRESETn)
        PREADY |=> !PREADY);

    // master must hold the address from the setup phase through ready
    a_paddr_stable: assert property (@(posedge PCLK) disable iff (!PRESETn)
        (state_q inside {rtc_pkg::ST_SETUP, rtc_pkg::ST_WRITE, rtc_pkg::ST_READ,
                         rtc_pkg::ST_RESP})
        |-> $stable(PADDR));

endmodule

// File: design/rtc_top.sv
// RTC peripheral top, ties tick sync, counter, alarm and APB control to the chip pins
`timescale 1ns/1ps

module rtc_top (
    input  logic                           PCLK,
    input  logic                           PRESETn,
    // APB slave
    input  logic                           PSEL,
    input  logic                           PENABLE,
    input  logic                           PWRITE,
    input  logic [rtc_pkg::ADDR_WIDTH-1:0] PADDR,
    input  logic [rtc_pkg::DATA_WIDTH-1:0] PWDATA,
    output logic [rtc_pkg::DATA_WIDTH-1:0] PRDATA,
    output logic                           PREADY,
    output logic                           PSLVERR,
    // slow time base
    input  logic                           CLK1HZ,
    // interrupt and its copy
    output logic                           RTCINTR,
    output logic                           rtc_trig
);

    // ========================================
    // internal nets
    // ========================================

    logic                           tick;
    logic [rtc_pkg::DATA_WIDTH-1:0] count;
    logic                           count_upd;
    logic                           enable;
    logic                           load_wr;
    logic [rtc_pkg::DATA_WIDTH-1:0] load_data;
    logic                           match_wr;
    logic [rtc_pkg::DATA_WIDTH-1:0] match_data;
    logic                           mask_wr;
    logic                           mask_data;
    logic                           clear;
    logic [rtc_pkg::DATA_WIDTH-1:0] match_value;
    logic                           mask;
    logic                           raw_status;

    // no error responses
    assign PSLVERR  = 1'b0;
    assign rtc_trig = RTCINTR;

    // producer, CLK1HZ edge to tick
    rtc_tick_sync u_tick_sync (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .CLK1HZ  (CLK1HZ),
        .tick    (tick)
    );

    // time store
    rtc_counter u_counter (
        .PCLK      (PCLK),
        .PRESETn   (PRESETn),
        .tick      (tick),
        .enable    (enable),
        .load_wr   (load_wr),
        .load_data (load_data),
        .count     (count),
        .count_upd (count_upd)
    );

    // consumer, match and interrupt
    rtc_alarm u_alarm (
        .PCLK        (PCLK),
        .PRESETn     (PRESETn),
        .count       (count),
        .count_upd   (count_upd),
        .match_wr    (match_wr),
        .match_data  (match_data),
        .mask_wr     (mask_wr),
        .mask_data   (mask_data),
        .clear       (clear),
        .match_value (match_value),
        .mask        (mask),
        .raw_status  (raw_status),
        .intr        (RTCINTR)
    );

    // register access over APB
    rtc_control u_control (
        .PCLK        (PCLK),
        .PRESETn     (PRESETn),
        .PSEL        (PSEL),
        .PENABLE     (PENABLE),
        .PWRITE      (PWRITE),
        .PADDR       (PADDR),
        .PWDATA      (PWDATA),
        .PRDATA      (PRDATA),
        .PREADY      (PREADY),
        .count       (count),
        .match_value (match_value),
        .mask        (mask),
        .raw_status  (raw_status),
        .load_wr     (load_wr),
        .load_data   (load_data),
        .enable      (enable),
        .match_wr    (match_wr),
        .match_data  (match_data),
        .mask_wr     (mask_wr),
        .mask_data   (mask_data),
        .clear       (clear)
    );

endmodule

// File: sim/tb_clock.sv
// PCLK source and power-on reset for the RTC testbench, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock (
    output logic PCLK,
    output logic PRESETn
);

    // 40 ns period
    initial begin
        PCLK = 1'b0;
        forever #20 PCLK = ~PCLK;
    end

    // reset low for the first 16 rising edges
    initial begin
        PRESETn = 1'b0;
        repeat (16) @(posedge PCLK);
        PRESETn <= 1'b1;
    end

endmodule

// File: sim/rtc_checker.sv
// reference model of the RTC registers that compares every APB transfer and the interrupt pins
`timescale 1ns/1ps

module rtc_checker (
    input  logic        PCLK,
    input  logic        PRESETn,
    input  logic        PSEL,
    input  logic        PENABLE,
    input  logic        PWRITE,
    input  logic [11:0] PADDR,
    input  logic [31:0] PWDATA,
    input  logic [31:0] PRDATA,
    input  logic        PREADY,
    input  logic        PSLVERR,
    input  logic        CLK1HZ,
    input  logic        RTCINTR,
    input  logic        rtc_trig,
    output int          error_count,
    output int          check_count,
    // model time used to pick match values
    output logic [31:0] model_count
);

    // ========================================
    // model state
    // ========================================

    logic [31:0] m_count;
    logic [31:0] m_match;
    logic [31:0] m_load;
    logic        m_enable;
    logic        m_mask;
    logic        m_raw;
    logic        clk1hz_q;
    // saturating count of cycles since the last CLK1HZ rise
    int          since_edge;
    logic [31:0] exp_data;
    logic        exp_intr;

    assign model_count = m_count;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    // register map view of the model where holes read zero
    function automatic logic [31:0] expected_read(input logic [11:0] addr);
        case (addr)
            rtc_pkg::RA_DR:   expected_read = m_count;
            rtc_pkg::RA_MR:   expected_read = m_match;
            rtc_pkg::RA_LR:   expected_read = m_load;
            rtc_pkg::RA_CR:   expected_read = {31'd0, m_enable};
            rtc_pkg::RA_IMSC: expected_read = {31'd0, m_mask};
            rtc_pkg::RA_RIS:  expected_read = {31'd0, m_raw};
            rtc_pkg::RA_MIS:  expected_read = {31'd0, m_raw & m_mask};
            default:          expected_read = 32'd0;
        endcase
    endfunction

    // ========================================
    // model update and compare
    // ========================================

    always @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            m_count    <= 32'd0;
            m_match    <= 32'd0;
            m_load     <= 32'd0;
            m_enable   <= 1'b0;
            m_mask     <= 1'b0;
            m_raw      <= 1'b0;
            clk1hz_q   <= 1'b0;
            since_edge <= 100;
        end else begin
            clk1hz_q <= CLK1HZ;
            if (since_edge < 100) begin
                since_edge <= since_edge + 1;
            end
            // one second per CLK1HZ rise while counting
            if (CLK1HZ && !clk1hz_q) begin
                since_edge <= 0;
                if (m_enable) begin
                    m_count <= m_count + 32'd1;
                    if (m_count + 32'd1 == m_match) begin
                        m_raw <= 1'b1;
                    end
                end
            end
            // the tick pipeline must be drained before a transfer
            if (PSEL && !PENABLE && since_edge <= rtc_pkg::SYNC_STAGES + 2) begin
                $display("transfer at t=%0t began %0d cycles after a CLK1HZ edge, too soon",
                         $time, since_edge);
                error_count = error_count + 1;
            end
            // completed transfer
            if (PSEL && PENABLE && PREADY) begin
                // the slave never answers with an error
                if (PSLVERR !== 1'b0) begin
                    $display("Error t=%0t PSLVERR expected 0 actual %0b", $time, PSLVERR);
                    error_count = error_count + 1;
                end
                if (PWRITE) begin
                    case (PADDR)
                        rtc_pkg::RA_MR:   m_match <= PWDATA;
                        // a load also counts as a count update for the match
                        rtc_pkg::RA_LR: begin
                            m_count <= PWDATA;
                            m_load  <= PWDATA;
                            if (PWDATA == m_match) begin
                                m_raw <= 1'b1;
                            end
                        end
                        rtc_pkg::RA_CR:   m_enable <= PWDATA[0];
                        rtc_pkg::RA_IMSC: m_mask   <= PWDATA[0];
                        rtc_pkg::RA_ICR: begin
                            if (PWDATA[0]) begin
                                m_raw <= 1'b0;
                            end
                        end
                        default: begin
                        end
                    endcase
                end else begin
                    exp_data    = expected_read(PADDR);
                    exp_intr    = m_raw & m_mask;
                    check_count = check_count + 1;
                    if (PRDATA !== exp_data) begin
                        $display("Error t=%0t PRDATA at 0x%03h expected 0x%08h actual 0x%08h",
                                 $time, PADDR, exp_data, PRDATA);
                        error_count = error_count + 1;
                    end
                    if (RTCINTR !== exp_intr) begin
                        $display("Error t=%0t RTCINTR expected %0b actual %0b",
                                 $time, exp_intr, RTCINTR);
                        error_count = error_count + 1;
                    end
                    if (rtc_trig !== exp_intr) begin
                        $display("Error t=%0t rtc_trig expected %0b actual %0b",
                                 $time, exp_intr, rtc_trig);
                        error_count = error_count + 1;
                    end
                end
            end
        end
    end

endmodule

// File: sim/rtc_tb.sv
// RTC testbench top that drives APB and CLK1HZ from an LFSR and reports results
`timescale 1ns/1ps

module rtc_tb;

    logic        PCLK;
    logic        PRESETn;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [11:0] PADDR;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;
    logic        CLK1HZ;
    logic        RTCINTR;
    logic        rtc_trig;
    int          error_count;
    int          check_count;
    logic [31:0] model_count;

    logic [31:0] lfsr_state = 32'hed6c;
    int          test_num = 1;
    int          tests_failed = 0;
    int          err_base = 0;
    int          cycle_count = 0;
    // transfers per test 10, 4, 4, 8, 9, 40
    int          trans_total = 75;
    // worst-case ticks per test plus one hold per burst
    int          tick_total = 17 + 26 + 9 + 8 + 200;
    int          limit_cycles;

    logic [31:0] rnd;
    logic [31:0] val;
    logic [31:0] data;
    logic [11:0] addr;
    int          i;

    tb_clock u_clock (
        .PCLK    (PCLK),
        .PRESETn (PRESETn)
    );

    rtc_top u_rtc_top (
        .PCLK     (PCLK),
        .PRESETn  (PRESETn),
        .PSEL     (PSEL),
        .PENABLE  (PENABLE),
        .PWRITE   (PWRITE),
        .PADDR    (PADDR),
        .PWDATA   (PWDATA),
        .PRDATA   (PRDATA),
        .PREADY   (PREADY),
        .PSLVERR  (PSLVERR),
        .CLK1HZ   (CLK1HZ),
        .RTCINTR  (RTCINTR),
        .rtc_trig (rtc_trig)
    );

    rtc_checker u_checker (
        .PCLK        (PCLK),
        .PRESETn     (PRESETn),
        .PSEL        (PSEL),
        .PENABLE     (PENABLE),
        .PWRITE      (PWRITE),
        .PADDR       (PADDR),
        .PWDATA      (PWDATA),
        .PRDATA      (PRDATA),
        .PREADY      (PREADY),
        .PSLVERR     (PSLVERR),
        .CLK1HZ      (CLK1HZ),
        .RTCINTR     (RTCINTR),
        .rtc_trig    (rtc_trig),
        .error_count (error_count),
        .check_count (check_count),
        .model_count (model_count)
    );

    // ========================================
    // helpers
    // ========================================

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int nbits, output logic [31:0] value);
        int k;
        value = 32'd0;
        for (k = 0; k < nbits; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // setup and access phases held until ready
    task automatic apb_write(input logic [11:0] waddr, input logic [31:0] wdata);
        @(posedge PCLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b1;
        PADDR   <= waddr;
        PWDATA  <= wdata;
        @(posedge PCLK);
        PENABLE <= 1'b1;
        @(posedge PCLK);
        while (!PREADY) @(posedge PCLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    // read transfer held until ready
    task automatic apb_read(input logic [11:0] raddr);
        @(posedge PCLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= 1'b0;
        PADDR   <= raddr;
        @(posedge PCLK);
        PENABLE <= 1'b1;
        @(posedge PCLK);
        while (!PREADY) @(posedge PCLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    // CLK1HZ bursts with an 8-cycle period and a quiet hold after
    task automatic run_ticks(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(posedge PCLK);
            CLK1HZ <= 1'b1;
            repeat (3) @(posedge PCLK);
            @(posedge PCLK);
            CLK1HZ <= 1'b0;
            repeat (3) @(posedge PCLK);
        end
        repeat (8) @(posedge PCLK);
    endtask

    // per-test result line from the checker's error count
    task automatic end_test(input string name);
        int fails;
        repeat (2) @(posedge PCLK);
        fails = error_count - err_base;
        if (fails == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, fails);
            tests_failed = tests_failed + 1;
        end
        test_num = test_num + 1;
        err_base = error_count;
    endtask

    // ========================================
    // run limit
    // ========================================

    always @(posedge PCLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= limit_cycles) begin
            $display("timeout, run still busy after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ========================================
    // test sequence
    // ========================================

    initial begin
        limit_cycles = 2 * (trans_total * 6 + tick_total * 8);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = 12'h000;
        PWDATA  = 32'd0;
        CLK1HZ  = 1'b0;
        wait (PRESETn === 1'b1);
        @(posedge PCLK);

        // reset values and register holes
        for (i = 0; i < 8; i++) begin
            apb_read(i * 4);
        end
        apb_read(12'h020);
        apb_read(12'hFFC);
        end_test("reset_values");

        // load with counting off
        apb_write(rtc_pkg::RA_CR, 32'd0);
        draw_bits(32, data);
        apb_write(rtc_pkg::RA_LR, data);
        draw_bits(4, rnd);
        run_ticks(rnd + 1);
        apb_read(rtc_pkg::RA_DR);
        apb_read(rtc_pkg::RA_LR);
        end_test("load_hold");

        // counting and then a wrap from all ones
        apb_write(rtc_pkg::RA_CR, 32'd1);
        draw_bits(4, rnd);
        run_ticks(rnd + 1);
        apb_read(rtc_pkg::RA_DR);
        apb_write(rtc_pkg::RA_LR, 32'hFFFF_FFFF);
        draw_bits(3, rnd);
        run_ticks(rnd + 1);
        apb_read(rtc_pkg::RA_DR);
        end_test("count_wrap");

        // match with the mask closed and then opened
        apb_write(rtc_pkg::RA_ICR, 32'd1);
        apb_write(rtc_pkg::RA_IMSC, 32'd0);
        draw_bits(3, rnd);
        rnd = rnd % 6 + 1;
        apb_write(rtc_pkg::RA_MR, model_count + rnd);
        run_ticks(rnd + 2);
        apb_read(rtc_pkg::RA_RIS);
        apb_read(rtc_pkg::RA_MIS);
        apb_write(rtc_pkg::RA_IMSC, 32'd1);
        apb_read(rtc_pkg::RA_MIS);
        apb_read(rtc_pkg::RA_RIS);
        end_test("match_mask");

        // clear and a second match
        apb_write(rtc_pkg::RA_ICR, 32'd1);
        apb_read(rtc_pkg::RA_RIS);
        apb_read(rtc_pkg::RA_MIS);
        draw_bits(3, rnd);
        rnd = rnd % 6 + 1;
        apb_write(rtc_pkg::RA_MR, model_count + rnd);
        run_ticks(rnd + 1);
        apb_read(rtc_pkg::RA_RIS);
        apb_read(rtc_pkg::RA_MIS);
        apb_write(rtc_pkg::RA_ICR, 32'd1);
        apb_read(rtc_pkg::RA_RIS);
        apb_read(rtc_pkg::RA_MIS);
        end_test("clear_rematch");

        // mixed traffic on mostly decoded registers
        for (i = 0; i < 40; i++) begin
            draw_bits(4, rnd);
            if (rnd >= 14) begin
                addr = (rnd == 14) ? 12'h020 : 12'hFFC;
            end else begin
                addr = {7'd0, rnd[2:0], 2'b00};
            end
            draw_bits(1, val);
            if (val[0]) begin
                // match values close to the count so hits occur
                if (addr == rtc_pkg::RA_MR) begin
                    draw_bits(3, rnd);
                    data = model_count + rnd;
                end else begin
                    draw_bits(32, data);
                end
                apb_write(addr, data);
            end else begin
                apb_read(addr);
            end
            draw_bits(1, val);
            if (val[0]) begin
                draw_bits(2, rnd);
                run_ticks(rnd + 1);
            end
        end
        end_test("random_mix");

        $display("tests %0d, failed %0d, reads checked %0d, errors %0d",
                 test_num - 1, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
design/rtc_pkg.sv
design/rtc_tick_sync.sv
design/rtc_counter.sv
design/rtc_alarm.sv
design/rtc_control.sv
design/rtc_top.sv
sim/tb_clock.sv
sim/rtc_checker.sv
sim/rtc_tb.sv
